//--- verilog/rsrc_pkg.sv
package rsrc_pkg;

  // ----------------------------------------------------------
  // sizes
  // ----------------------------------------------------------
  localparam int DISP_SIZE   = 2;

  localparam int ROB_SIZE    = 16;
  localparam int ALU_RS_SIZE = 8;
  localparam int LDQ_SIZE    = 8;
  localparam int STQ_SIZE    = 8;
  localparam int BR_TAG_NUM  = 4;

  // demand count must hold DISP_SIZE itself
  localparam int CNT_W   = $clog2(DISP_SIZE + 1);
  // credit value must hold the largest queue size
  localparam int CRED_W  = $clog2(ROB_SIZE + 1);
  localparam int BRTAG_W = $clog2(BR_TAG_NUM);

  // ----------------------------------------------------------
  // instruction categories
  // ----------------------------------------------------------
  typedef enum logic [2:0] {
    CAT_NOP = 3'd0,
    CAT_ALU = 3'd1,
    CAT_LD  = 3'd2,
    CAT_ST  = 3'd3,
    CAT_BR  = 3'd4
  } inst_cat_e;

  // ----------------------------------------------------------
  // dispatch group and allocator structs
  // ----------------------------------------------------------
  typedef struct packed {
    logic      valid;
    inst_cat_e cat;
  } disp_slot_t;

  // slot 0 is the oldest instruction of the group
  typedef disp_slot_t [DISP_SIZE-1:0] disp_grp_t;

  // entries needed per back-end queue
  typedef struct packed {
    logic [CNT_W-1:0] rob;
    logic [CNT_W-1:0] alu;
    logic [CNT_W-1:0] ld;
    logic [CNT_W-1:0] st;
    logic [CNT_W-1:0] br;
  } demand_t;

  typedef struct packed {
    logic             valid;
    logic [CNT_W-1:0] cnt;
  } cre_ret_t;

  typedef struct packed {
    logic               valid;
    logic [BRTAG_W-1:0] tag;
  } br_cmt_t;

  // mask has a bit set for every tag busy up to this slot
  typedef struct packed {
    logic [BRTAG_W-1:0]    tag;
    logic [BR_TAG_NUM-1:0] mask;
  } brtag_out_t;

endpackage

//--- verilog/disp_demand.sv
module disp_demand (
  input  logic                              i_disp_valid,
  input  rsrc_pkg::disp_grp_t               i_disp_grp,
  output rsrc_pkg::demand_t                 o_demand,
  output logic [rsrc_pkg::DISP_SIZE-1:0]    o_is_br
);
  import rsrc_pkg::*;

  // ----------------------------------------------------------
  // per-queue counts
  // ----------------------------------------------------------
  always_comb begin
    o_demand = '0;
    if (i_disp_valid) begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_disp_grp[d].valid) begin
          // every valid slot needs a ROB entry, nops included
          o_demand.rob = o_demand.rob + CNT_W'(1);
          case (i_disp_grp[d].cat)
            CAT_ALU: begin
              o_demand.alu = o_demand.alu + CNT_W'(1);
            end
            CAT_LD: begin
              o_demand.ld = o_demand.ld + CNT_W'(1);
            end
            CAT_ST: begin
              o_demand.st = o_demand.st + CNT_W'(1);
            end
            CAT_BR: begin
              o_demand.br = o_demand.br + CNT_W'(1);
            end
            default: begin
              // nop uses only the ROB
            end
          endcase
        end
      end
    end
  end

  // ----------------------------------------------------------
  // branch flags per slot
  // ----------------------------------------------------------
  always_comb begin
    o_is_br = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_is_br[d] = i_disp_valid &&
                   i_disp_grp[d].valid &&
                   (i_disp_grp[d].cat == CAT_BR);
    end
  end

endmodule

//--- verilog/credit_counter.sv
module credit_counter #(
  parameter int MAX_CREDITS = 8
) (
  input  logic                           i_clk,
  input  logic                           i_reset_n,

  // take side, from dispatch
  input  logic                           i_take,
  input  logic [rsrc_pkg::CNT_W-1:0]     i_take_cnt,

  // return side, from the queue
  input  rsrc_pkg::cre_ret_t             i_ret,

  output logic                           o_enough,
  output logic [rsrc_pkg::CRED_W-1:0]    o_credits
);
  import rsrc_pkg::*;

  logic [CRED_W-1:0] r_credits;
  logic [CRED_W-1:0] w_credits_next;

  // take and return may land in the same cycle
  always_comb begin
    w_credits_next = r_credits;
    if (i_take) begin
      w_credits_next = w_credits_next - CRED_W'(i_take_cnt);
    end
    if (i_ret.valid) begin
      w_credits_next = w_credits_next + CRED_W'(i_ret.cnt);
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_credits <= CRED_W'(MAX_CREDITS);
    end else begin
      r_credits <= w_credits_next;
    end
  end

  // demand is zero when no group is offered
  assign o_enough  = (r_credits >= CRED_W'(i_take_cnt));
  assign o_credits = r_credits;

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  // returns beyond what was taken would overflow the queue
  a_cred_cap: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    r_credits <= CRED_W'(MAX_CREDITS)
  ) else $error("credit count above capacity");

  // fire from the control block must respect this counter
  a_take_ok: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_take |-> o_enough
  ) else $error("credits taken while not enough");

endmodule

//--- verilog/brtag_alloc.sv
module brtag_alloc (
  input  logic                               i_clk,
  input  logic                               i_reset_n,

  input  logic [rsrc_pkg::DISP_SIZE-1:0]     i_is_br,
  input  logic                               i_fire,
  input  rsrc_pkg::br_cmt_t                  i_cmt,
  input  logic                               i_flush,

  output logic                               o_enough,
  output rsrc_pkg::brtag_out_t               o_brtag [rsrc_pkg::DISP_SIZE]
);
  import rsrc_pkg::*;

  logic [BR_TAG_NUM-1:0] r_busy;
  logic [BRTAG_W-1:0]    r_last_tag;
  logic [BR_TAG_NUM-1:0] w_busy_cmt;

  // running mask and tag, entry 0 is the state before slot 0
  logic [BR_TAG_NUM-1:0] w_mask [DISP_SIZE+1];
  logic [BRTAG_W-1:0]    w_tag  [DISP_SIZE+1];

  logic [BRTAG_W:0]      w_free_cnt;
  logic [CNT_W-1:0]      w_br_cnt;

  // committed tag is free again this cycle
  always_comb begin
    w_busy_cmt = r_busy;
    if (i_cmt.valid) begin
      w_busy_cmt[i_cmt.tag] = 1'b0;
    end
  end

  // ----------------------------------------------------------
  // lowest-free allocation, slot by slot
  // ----------------------------------------------------------
  always_comb begin
    logic               found;
    logic [BRTAG_W-1:0] free_idx;
    w_mask[0] = w_busy_cmt;
    w_tag[0]  = r_last_tag;
    for (int d = 0; d < DISP_SIZE; d++) begin
      found    = 1'b0;
      free_idx = '0;
      for (int b = 0; b < BR_TAG_NUM; b++) begin
        if (!found && !w_mask[d][b]) begin
          found    = 1'b1;
          free_idx = BRTAG_W'(b);
        end
      end
      w_mask[d+1] = w_mask[d];
      w_tag[d+1]  = w_tag[d];
      if (i_is_br[d] && found) begin
        w_mask[d+1] = w_mask[d] | (BR_TAG_NUM'(1) << free_idx);
        w_tag[d+1]  = free_idx;
      end
    end
  end

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_out
    assign o_brtag[d].tag  = w_tag[d+1];
    assign o_brtag[d].mask = w_mask[d+1];
  end

  // free tags against branches in the group
  always_comb begin
    w_free_cnt = '0;
    w_br_cnt   = '0;
    for (int b = 0; b < BR_TAG_NUM; b++) begin
      w_free_cnt = w_free_cnt + (BRTAG_W+1)'(!w_busy_cmt[b]);
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_br_cnt = w_br_cnt + CNT_W'(i_is_br[d]);
    end
  end

  assign o_enough = (w_free_cnt >= (BRTAG_W+1)'(w_br_cnt));

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_busy     <= '0;
      r_last_tag <= '0;
    end else if (i_flush) begin
      // flush kills every branch in flight
      r_busy     <= '0;
      r_last_tag <= '0;
    end else if (i_fire) begin
      r_busy     <= w_mask[DISP_SIZE];
      r_last_tag <= w_tag[DISP_SIZE];
    end else begin
      r_busy     <= w_busy_cmt;
    end
  end

  // back end may only commit a tag handed out earlier
  a_cmt_busy: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_cmt.valid |-> r_busy[i_cmt.tag]
  ) else $error("commit of a free branch tag");

endmodule

//--- verilog/rsrc_ctrl.sv
module rsrc_ctrl (
  input  logic i_disp_valid,
  input  logic i_flush,

  // sufficiency flags, one per back-end resource
  input  logic i_rob_ok,
  input  logic i_alu_ok,
  input  logic i_ldq_ok,
  input  logic i_stq_ok,
  input  logic i_br_ok,

  output logic o_ready,
  output logic o_fire
);

  logic [4:0] w_ok_vec;

  // ----------------------------------------------------------
  // ready
  // ----------------------------------------------------------
  // order matches the queue list, rob first
  assign w_ok_vec = {i_rob_ok, i_alu_ok, i_ldq_ok, i_stq_ok, i_br_ok};

  // any queue short of room holds the whole group
  assign o_ready = &w_ok_vec;

  // ----------------------------------------------------------
  // fire
  // ----------------------------------------------------------
  // a flush cycle takes nothing, even with a ready group
  assign o_fire = i_disp_valid & o_ready & ~i_flush;

endmodule

//--- verilog/rsrc_alloc_top.sv
module rsrc_alloc_top (
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  // dispatch group
  input  logic                   i_disp_valid,
  input  rsrc_pkg::disp_grp_t    i_disp_grp,
  output logic                   o_disp_ready,
  output logic                   o_disp_fire,

  // credit returns and branch commit
  input  rsrc_pkg::cre_ret_t     i_rob_ret,
  input  rsrc_pkg::cre_ret_t     i_alu_ret,
  input  rsrc_pkg::cre_ret_t     i_ldq_ret,
  input  rsrc_pkg::cre_ret_t     i_stq_ret,
  input  rsrc_pkg::br_cmt_t      i_br_cmt,
  input  logic                   i_flush,

  output rsrc_pkg::brtag_out_t   o_brtag [rsrc_pkg::DISP_SIZE]
);
  import rsrc_pkg::*;

  demand_t              w_demand;
  logic [DISP_SIZE-1:0] w_is_br;
  logic                 w_fire;
  logic                 w_rob_ok;
  logic                 w_alu_ok;
  logic                 w_ldq_ok;
  logic                 w_stq_ok;
  logic                 w_br_ok;

  disp_demand u_disp_demand (
    .i_disp_valid (i_disp_valid),
    .i_disp_grp   (i_disp_grp),
    .o_demand     (w_demand),
    .o_is_br      (w_is_br)
  );

  // ----------------------------------------------------------
  // queue credits
  // ----------------------------------------------------------
  credit_counter #(.MAX_CREDITS(ROB_SIZE)) u_rob_credit (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_take     (w_fire),
    .i_take_cnt (w_demand.rob),
    .i_ret      (i_rob_ret),
    .o_enough   (w_rob_ok),
    .o_credits  ()
  );

  credit_counter #(.MAX_CREDITS(ALU_RS_SIZE)) u_alu_credit (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_take     (w_fire),
    .i_take_cnt (w_demand.alu),
    .i_ret      (i_alu_ret),
    .o_enough   (w_alu_ok),
    .o_credits  ()
  );

  credit_counter #(.MAX_CREDITS(LDQ_SIZE)) u_ldq_credit (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_take     (w_fire),
    .i_take_cnt (w_demand.ld),
    .i_ret      (i_ldq_ret),
    .o_enough   (w_ldq_ok),
    .o_credits  ()
  );

  credit_counter #(.MAX_CREDITS(STQ_SIZE)) u_stq_credit (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_take     (w_fire),
    .i_take_cnt (w_demand.st),
    .i_ret      (i_stq_ret),
    .o_enough   (w_stq_ok),
    .o_credits  ()
  );

  // branch unit credit is the tag free list
  brtag_alloc u_brtag_alloc (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_is_br   (w_is_br),
    .i_fire    (w_fire),
    .i_cmt     (i_br_cmt),
    .i_flush   (i_flush),
    .o_enough  (w_br_ok),
    .o_brtag   (o_brtag)
  );

  rsrc_ctrl u_rsrc_ctrl (
    .i_disp_valid (i_disp_valid),
    .i_flush      (i_flush),
    .i_rob_ok     (w_rob_ok),
    .i_alu_ok     (w_alu_ok),
    .i_ldq_ok     (w_ldq_ok),
    .i_stq_ok     (w_stq_ok),
    .i_br_ok      (w_br_ok),
    .o_ready      (o_disp_ready),
    .o_fire       (w_fire)
  );

  assign o_disp_fire = w_fire;

endmodule

//--- testbench/tb_rsrc_alloc.sv
module tb_rsrc_alloc;
  import rsrc_pkg::*;

  // cycle budgets per test, used by the watchdog
  localparam int RESET_CYC   = 10;
  localparam int EXHAUST_CYC = 8;
  localparam int RANDOM_CYC  = 300;
  localparam int RESTORE_CYC = 20;
  localparam int RUN_CYC     = RESET_CYC + EXHAUST_CYC + 10 + 4 + 12 + 8 + RANDOM_CYC
                               + 6 * RESTORE_CYC;

  logic         clk;
  logic         reset_n;
  logic         disp_valid;
  disp_grp_t    disp_grp;
  logic         disp_ready;
  logic         disp_fire;
  cre_ret_t     ret [4];
  br_cmt_t      br_cmt;
  logic         flush;
  brtag_out_t   brtag [DISP_SIZE];

  // reference model state, queue order rob, alu, ldq, stq
  logic [CRED_W-1:0]     m_cred [4];
  logic [BR_TAG_NUM-1:0] m_busy;
  logic [BRTAG_W-1:0]    m_last_tag;
  logic                  last_fire;

  int                    exp_need [5];
  logic [BR_TAG_NUM-1:0] exp_cmt_mask;
  brtag_out_t            exp_brtag [DISP_SIZE];
  logic                  exp_ready;
  logic                  exp_fire;
  logic [CRED_W-1:0]     dut_cred [4];

  string cur_test = "reset";
  int    err_cnt;
  int    err_at_start;
  int    pass_cnt;
  int    fail_cnt;

  rsrc_alloc_top rsrc_alloc_top_inst (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_disp_valid (disp_valid),
    .i_disp_grp   (disp_grp),
    .o_disp_ready (disp_ready),
    .o_disp_fire  (disp_fire),
    .i_rob_ret    (ret[0]),
    .i_alu_ret    (ret[1]),
    .i_ldq_ret    (ret[2]),
    .i_stq_ret    (ret[3]),
    .i_br_cmt     (br_cmt),
    .i_flush      (flush),
    .o_brtag      (brtag)
  );

  assign dut_cred[0] = rsrc_alloc_top_inst.u_rob_credit.o_credits;
  assign dut_cred[1] = rsrc_alloc_top_inst.u_alu_credit.o_credits;
  assign dut_cred[2] = rsrc_alloc_top_inst.u_ldq_credit.o_credits;
  assign dut_cred[3] = rsrc_alloc_top_inst.u_stq_credit.o_credits;

  function automatic int queue_cap(int q);
    case (q)
      0:       return ROB_SIZE;
      1:       return ALU_RS_SIZE;
      2:       return LDQ_SIZE;
      default: return STQ_SIZE;
    endcase
  endfunction

  function automatic disp_slot_t make_slot(logic v, inst_cat_e c);
    disp_slot_t s;
    s.valid = v;
    s.cat   = c;
    return s;
  endfunction

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  always_comb begin
    logic [BR_TAG_NUM-1:0] mask;
    logic [BRTAG_W-1:0]    tag;
    int                    free_cnt;
    int                    pick;
    for (int q = 0; q < 5; q++) begin
      exp_need[q] = 0;
    end
    mask = m_busy;
    if (br_cmt.valid) begin
      mask[br_cmt.tag] = 1'b0;
    end
    exp_cmt_mask = mask;
    free_cnt = 0;
    for (int b = 0; b < BR_TAG_NUM; b++) begin
      if (!mask[b]) free_cnt++;
    end
    tag = m_last_tag;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (disp_valid && disp_grp[d].valid) begin
        exp_need[0]++;
        case (disp_grp[d].cat)
          CAT_ALU: exp_need[1]++;
          CAT_LD:  exp_need[2]++;
          CAT_ST:  exp_need[3]++;
          CAT_BR: begin
            exp_need[4]++;
            // lowest free tag wins
            pick = -1;
            for (int b = BR_TAG_NUM - 1; b >= 0; b--) begin
              if (!mask[b]) pick = b;
            end
            if (pick >= 0) begin
              tag = BRTAG_W'(pick);
              mask[pick] = 1'b1;
            end
          end
          default: ;
        endcase
      end
      exp_brtag[d].tag  = tag;
      exp_brtag[d].mask = mask;
    end
    exp_ready = (free_cnt >= exp_need[4]);
    for (int q = 0; q < 4; q++) begin
      if (int'(m_cred[q]) < exp_need[q]) exp_ready = 1'b0;
    end
    exp_fire = disp_valid && exp_ready && !flush;
  end

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      for (int q = 0; q < 4; q++) begin
        m_cred[q] <= CRED_W'(queue_cap(q));
      end
      m_busy     <= '0;
      m_last_tag <= '0;
      last_fire  <= 1'b0;
    end else begin
      for (int q = 0; q < 4; q++) begin
        m_cred[q] <= m_cred[q] - CRED_W'(exp_fire ? exp_need[q] : 0)
                     + CRED_W'(ret[q].valid ? ret[q].cnt : 0);
      end
      if (flush) begin
        m_busy     <= '0;
        m_last_tag <= '0;
      end else if (exp_fire) begin
        m_busy     <= exp_brtag[DISP_SIZE-1].mask;
        m_last_tag <= exp_brtag[DISP_SIZE-1].tag;
      end else begin
        m_busy     <= exp_cmt_mask;
      end
      last_fire <= disp_fire;
    end
  end

  // ----------------------------------------------------------
  // checks against the model
  // ----------------------------------------------------------
  task automatic report_mismatch(string what, longint exp_val, longint act_val);
    err_cnt++;
    $display("mismatch in %s: %s expected 0x%0h actual 0x%0h",
             cur_test, what, exp_val, act_val);
  endtask

  a_ready: assert property (@(posedge clk) disable iff (!reset_n) disp_ready == exp_ready)
    else report_mismatch("ready", $sampled(exp_ready), $sampled(disp_ready));

  a_fire: assert property (@(posedge clk) disable iff (!reset_n) disp_fire == exp_fire)
    else report_mismatch("fire", $sampled(exp_fire), $sampled(disp_fire));

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_tag_chk
    a_tag: assert property (@(posedge clk) disable iff (!reset_n)
      disp_fire |-> brtag[d] == exp_brtag[d])
      else report_mismatch($sformatf("slot %0d tag and mask", d),
                           $sampled(exp_brtag[d]), $sampled(brtag[d]));
  end

  for (genvar q = 0; q < 4; q++) begin : g_cred_chk
    a_cred: assert property (@(posedge clk) disable iff (!reset_n) dut_cred[q] == m_cred[q])
      else report_mismatch($sformatf("queue %0d credits", q),
                           $sampled(m_cred[q]), $sampled(dut_cred[q]));
    a_cap: assert property (@(posedge clk) disable iff (!reset_n)
      int'(dut_cred[q]) <= queue_cap(q))
      else begin
        err_cnt++;
        $display("queue %0d credit count went above capacity in %s", q, cur_test);
      end
  end

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------
  task automatic next_cycle();
    @(posedge clk);
    #1;
    for (int q = 0; q < 4; q++) begin
      ret[q] = '0;
    end
    br_cmt = '0;
    flush  = 1'b0;
  endtask

  // group stays on the bus until it transfers
  task automatic send_group(disp_slot_t s0, disp_slot_t s1);
    disp_valid  = 1'b1;
    disp_grp[0] = s0;
    disp_grp[1] = s1;
    do begin
      next_cycle();
    end while (!last_fire);
    disp_valid = 1'b0;
  endtask

  // hand back every credit and tag the model still counts as taken
  task automatic restore_all();
    int room;
    disp_valid = 1'b0;
    while (m_busy != '0 || m_cred[0] != ROB_SIZE || m_cred[1] != ALU_RS_SIZE ||
           m_cred[2] != LDQ_SIZE || m_cred[3] != STQ_SIZE) begin
      for (int q = 0; q < 4; q++) begin
        room = queue_cap(q) - int'(m_cred[q]);
        if (room > 0) begin
          ret[q].valid = 1'b1;
          ret[q].cnt   = CNT_W'((room > 2) ? 2 : room);
        end
      end
      for (int b = BR_TAG_NUM - 1; b >= 0; b--) begin
        if (m_busy[b]) begin
          br_cmt.valid = 1'b1;
          br_cmt.tag   = BRTAG_W'(b);
        end
      end
      next_cycle();
    end
    next_cycle();
  endtask

  task automatic start_test(string name);
    cur_test     = name;
    err_at_start = err_cnt;
  endtask

  task automatic report_test();
    if (err_cnt == err_at_start) begin
      pass_cnt++;
      $display("test %s: pass", cur_test);
    end else begin
      fail_cnt++;
      $display("test %s: fail with %0d errors", cur_test, err_cnt - err_at_start);
    end
  endtask

  task automatic finish_test();
    restore_all();
    report_test();
  endtask

  // ----------------------------------------------------------
  // clock, reset, watchdog
  // ----------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (RUN_CYC + 200) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $finish;
  end

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin
    int room;
    int pick;
    void'($urandom(70252));
    reset_n    = 1'b0;
    disp_valid = 1'b0;
    disp_grp   = '0;
    for (int q = 0; q < 4; q++) begin
      ret[q] = '0;
    end
    br_cmt = '0;
    flush  = 1'b0;
    repeat (RESET_CYC) @(posedge clk);
    #1;
    reset_n = 1'b1;
    next_cycle();

    // two loads per group drain the LDQ in four groups
    start_test("credit_exhaustion");
    disp_valid  = 1'b1;
    disp_grp[0] = make_slot(1'b1, CAT_LD);
    disp_grp[1] = make_slot(1'b1, CAT_LD);
    repeat (EXHAUST_CYC) next_cycle();
    report_test();

    // group still waiting, credits trickle back one at a time
    start_test("credit_return");
    for (int i = 0; i < 4; i++) begin
      ret[2].valid = 1'b1;
      ret[2].cnt   = CNT_W'(1);
      next_cycle();
      next_cycle();
    end
    finish_test();

    start_test("tag_allocation");
    send_group(make_slot(1'b1, CAT_BR), make_slot(1'b1, CAT_BR));
    report_test();

    start_test("tag_exhaustion");
    send_group(make_slot(1'b1, CAT_BR), make_slot(1'b1, CAT_ALU));
    send_group(make_slot(1'b1, CAT_ALU), make_slot(1'b1, CAT_BR));
    disp_valid  = 1'b1;
    disp_grp[0] = make_slot(1'b1, CAT_BR);
    disp_grp[1] = make_slot(1'b0, CAT_NOP);
    repeat (3) next_cycle();
    // freed tag goes straight back out in the same cycle
    br_cmt.valid = 1'b1;
    br_cmt.tag   = BRTAG_W'(1);
    next_cycle();
    disp_valid = 1'b0;
    finish_test();

    start_test("flush");
    send_group(make_slot(1'b1, CAT_BR), make_slot(1'b1, CAT_BR));
    flush = 1'b1;
    send_group(make_slot(1'b1, CAT_ALU), make_slot(1'b1, CAT_LD));
    send_group(make_slot(1'b1, CAT_BR), make_slot(1'b1, CAT_NOP));
    finish_test();

    start_test("mixed_random");
    for (int i = 0; i < RANDOM_CYC; i++) begin
      if (!disp_valid || last_fire) begin
        disp_valid = ($urandom_range(3) != 0);
        for (int d = 0; d < DISP_SIZE; d++) begin
          disp_grp[d] = make_slot($urandom_range(3) != 0, inst_cat_e'($urandom_range(4)));
        end
      end
      for (int q = 0; q < 4; q++) begin
        room = queue_cap(q) - int'(m_cred[q]);
        if (room > 0 && $urandom_range(1) == 1) begin
          ret[q].valid = 1'b1;
          ret[q].cnt   = CNT_W'($urandom_range(1, (room > 2) ? 2 : room));
        end
      end
      pick = $urandom_range(BR_TAG_NUM - 1);
      if (m_busy[pick] && $urandom_range(3) == 0) begin
        br_cmt.valid = 1'b1;
        br_cmt.tag   = BRTAG_W'(pick);
      end
      flush = ($urandom_range(49) == 0);
      next_cycle();
    end
    finish_test();

    $display("tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- sim.f
verilog/rsrc_pkg.sv
verilog/disp_demand.sv
verilog/credit_counter.sv
verilog/brtag_alloc.sv
verilog/rsrc_ctrl.sv
verilog/rsrc_alloc_top.sv
testbench/tb_rsrc_alloc.sv

//--- Bender.yml
package:
  name: rsrc_alloc

sources:
  - verilog/rsrc_pkg.sv
  - verilog/disp_demand.sv
  - verilog/credit_counter.sv
  - verilog/brtag_alloc.sv
  - verilog/rsrc_ctrl.sv
  - verilog/rsrc_alloc_top.sv
  - target: simulation
    files:
      - testbench/tb_rsrc_alloc.sv
